// File: hdl/lookup_tables.sv
//**************************************************************************
// Lookup table subsystem top.
// PIO decoder, four table banks and the PIO response merger.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module lookup_tables (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire logic                      clk_div,
	input  wire pio_pkg::pio_word_t        reg_addr,
	input  wire pio_pkg::pio_word_t        reg_din,
	input  wire logic                      reg_rd,
	input  wire logic                      reg_wr,
	input  wire logic [tbl_pkg::num_banks-1:0] app_mem_rd,
	input  wire tbl_pkg::tbl_addr_t [tbl_pkg::num_banks-1:0] app_mem_raddr,
	output      logic                      mem_ack,
	output      pio_pkg::pio_word_t        mem_rdata,
	output      logic [tbl_pkg::num_banks-1:0] app_mem_ack,
	output      tbl_pkg::tbl_data_t [tbl_pkg::num_banks-1:0] app_mem_rdata
);

	import pio_pkg::*;
	import tbl_pkg::*;

	logic [num_banks-1:0]      bank_ms;           // One-hot bank select.
	bank_idx_t                 req_bank;
	logic                      unmapped_rd;
	logic                      unmapped_wr;
	logic [num_banks-1:0]      bank_ack;          // Per-bank PIO acknowledge.
	pio_word_t [num_banks-1:0] bank_rdata;

	pio_decode u_decode (
		.reg_addr    (reg_addr),
		.reg_rd      (reg_rd),
		.reg_wr      (reg_wr),
		.bank_ms     (bank_ms),
		.req_bank    (req_bank),
		.unmapped_rd (unmapped_rd),
		.unmapped_wr (unmapped_wr)
	);

	// One bank per select line.
	for (genvar i = 0; i < num_banks; i++) begin : g_bank
		pio_mem u_bank (
			.clk           (clk),
			.arst_n        (arst_n),
			.clk_div       (clk_div),
			.reg_addr      (reg_addr),
			.reg_din       (reg_din),
			.reg_rd        (reg_rd),
			.reg_wr        (reg_wr),
			.reg_ms        (bank_ms[i]),
			.app_mem_rd    (app_mem_rd[i]),
			.app_mem_raddr (app_mem_raddr[i]),
			.mem_ack       (bank_ack[i]),
			.mem_rdata     (bank_rdata[i]),
			.app_mem_ack   (app_mem_ack[i]),
			.app_mem_rdata (app_mem_rdata[i])
		);
	end

	pio_resp_merge u_merge (
		.clk         (clk),
		.arst_n      (arst_n),
		.clk_div     (clk_div),
		.bank_ms     (bank_ms),
		.req_bank    (req_bank),
		.unmapped_rd (unmapped_rd),
		.unmapped_wr (unmapped_wr),
		.bank_ack    (bank_ack),
		.bank_rdata  (bank_rdata),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

// File: hdl/pio_decode.sv
//**************************************************************************
// PIO address decoder.
// One-hot bank select for mapped accesses, flags for unmapped ones.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pio_decode (
	input  wire pio_pkg::pio_word_t        reg_addr,
	input  wire logic                      reg_rd,
	input  wire logic                      reg_wr,
	output      logic [tbl_pkg::num_banks-1:0] bank_ms,
	output      tbl_pkg::bank_idx_t        req_bank,
	output      logic                      unmapped_rd,
	output      logic                      unmapped_wr
);

	import pio_pkg::*;
	import tbl_pkg::*;

	logic mapped;                                 // No address bit above the map.
	logic req;                                    // Any bus request this cycle.

	assign mapped = ~|reg_addr[pio_nbits-1:pio_map_msb+1];
	assign req    = reg_rd | reg_wr;

	// Bank number straight from the address field.
	assign req_bank = reg_addr[bank_lsb +: bank_sel_nbits];

	// One select per bank, only for a mapped request.
	always_comb begin
		for (int i = 0; i < num_banks; i++) begin
			bank_ms[i] = req & mapped & (req_bank == bank_idx_t'(i));
		end
	end

	// Unmapped accesses still need an answer.
	assign unmapped_rd = reg_rd & ~mapped;
	assign unmapped_wr = reg_wr & ~mapped;

endmodule

`default_nettype wire

// File: hdl/pio_mem.sv
//**************************************************************************
// One lookup table bank.
// Application reads own the RAM read port, PIO reads wait their turn.
// PIO acknowledge moves only on the divided clock strobe.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pio_mem (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               clk_div,
	input  wire pio_pkg::pio_word_t reg_addr,
	input  wire pio_pkg::pio_word_t reg_din,
	input  wire logic               reg_rd,
	input  wire logic               reg_wr,
	input  wire logic               reg_ms,
	input  wire logic               app_mem_rd,
	input  wire tbl_pkg::tbl_addr_t app_mem_raddr,
	output      logic               mem_ack,
	output      pio_pkg::pio_word_t mem_rdata,
	output      logic               app_mem_ack,
	output      tbl_pkg::tbl_data_t app_mem_rdata
);

	import pio_pkg::*;
	import tbl_pkg::*;

	logic      ram_wr;                            // PIO write to this bank.
	logic      ram_rd;                            // PIO read to this bank.
	tbl_addr_t word_idx;                          // Entry index from the bus address.
	tbl_addr_t ram_raddr;
	tbl_data_t ram_rdata;

	logic      app_rd_d1;                         // Application read owns the RAM now.
	logic      app_rd_d2;
	tbl_addr_t app_raddr_d1;

	logic      rd_save;                           // PIO read held back by a collision.
	tbl_addr_t rd_idx_q;                          // Its entry index.
	logic      rd_issue;                          // PIO read drives the RAM this cycle.
	logic      rd_issue_d1;                       // RAM data for PIO is valid.
	logic      rd_issue_d2;                       // PIO data captured.
	logic      n_mem_ack;                         // Ack pending the next strobe.

	assign ram_wr   = reg_ms & reg_wr;
	assign ram_rd   = reg_ms & reg_rd;
	assign word_idx = reg_addr[2 +: tbl_depth_nbits];  // Byte address to word.

	// PIO read goes out when no application read holds the port.
	assign rd_issue = ~app_rd_d1 & (ram_rd | rd_save);

	// Shared read address.
	always_comb begin
		if (app_rd_d1)
			ram_raddr = app_raddr_d1;                 // Application always wins.
		else if (rd_save)
			ram_raddr = rd_idx_q;                     // Deferred PIO read.
		else
			ram_raddr = word_idx;
	end

	// Control pipeline.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			app_rd_d1   <= 1'b0;
			app_rd_d2   <= 1'b0;
			app_mem_ack <= 1'b0;
			rd_save     <= 1'b0;
			rd_issue_d1 <= 1'b0;
			rd_issue_d2 <= 1'b0;
			n_mem_ack   <= 1'b0;
			mem_ack     <= 1'b0;
		end else begin
			app_rd_d1   <= app_mem_rd;
			app_rd_d2   <= app_rd_d1;
			app_mem_ack <= app_rd_d2;                 // Three cycles after the request.
			// Hold a collided read until it gets the port.
			if (ram_rd & app_rd_d1)
				rd_save <= 1'b1;
			else if (rd_issue)
				rd_save <= 1'b0;
			rd_issue_d1 <= rd_issue;
			rd_issue_d2 <= rd_issue_d1;
			// Set has priority over the strobe clear.
			if (ram_wr | rd_issue_d2)
				n_mem_ack <= 1'b1;
			else if (clk_div)
				n_mem_ack <= 1'b0;
			if (clk_div)
				mem_ack <= n_mem_ack;                 // Level, one strobe period wide.
		end
	end

	// Data path.
	always_ff @(posedge clk) begin
		app_raddr_d1  <= app_mem_raddr;
		app_mem_rdata <= ram_rdata;
		if (ram_rd)
			rd_idx_q <= word_idx;
		if (rd_issue_d1)
			mem_rdata <= {{(pio_nbits-tbl_width){1'b0}}, ram_rdata};  // Zero-extended.
	end

	ram_1r1w u_ram (
		.clk   (clk),
		.wr    (ram_wr),
		.raddr (ram_raddr),
		.waddr (word_idx),
		.din   (reg_din[tbl_width-1:0]),
		.dout  (ram_rdata)
	);

endmodule

`default_nettype wire

// File: hdl/pio_pkg.sv
//**************************************************************************
// PIO bus definitions.
// Bus word width, word type and the bank address map.
//**************************************************************************

`default_nettype none

package pio_pkg;

	// Address and data share one width.
	localparam int pio_nbits = 32;

	typedef logic [pio_nbits-1:0] pio_word_t;   // Bus address or data word.

	// Bus addresses are byte addresses.
	// Bits 1..0 are ignored and bits 11..2 index the word in a bank.
	localparam int bank_lsb       = 12;         // Lowest bit of the bank number.
	localparam int bank_sel_nbits = 2;          // Bank number is bits 13..12.

	// Any set bit above this one is an unmapped access.
	localparam int pio_map_msb = bank_lsb + bank_sel_nbits - 1;

endpackage

`default_nettype wire

// File: hdl/pio_resp_merge.sv
//**************************************************************************
// PIO response merger.
// Forwards the addressed bank's answer, answers unmapped accesses itself.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pio_resp_merge (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire logic                      clk_div,
	input  wire logic [tbl_pkg::num_banks-1:0] bank_ms,
	input  wire tbl_pkg::bank_idx_t        req_bank,
	input  wire logic                      unmapped_rd,
	input  wire logic                      unmapped_wr,
	input  wire logic [tbl_pkg::num_banks-1:0] bank_ack,
	input  wire pio_pkg::pio_word_t [tbl_pkg::num_banks-1:0] bank_rdata,
	output      logic                      mem_ack,
	output      pio_pkg::pio_word_t        mem_rdata
);

	import tbl_pkg::*;

	bank_idx_t bank_q;                            // Last mapped bank.
	logic      unm_pend;                          // Last request was unmapped.
	logic      n_unm_ack;                         // Unmapped ack pending the strobe.
	logic      unm_ack;
	logic      mapped_req;
	logic      unm_req;

	assign mapped_req = |bank_ms;
	assign unm_req    = unmapped_rd | unmapped_wr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bank_q    <= '0;
			unm_pend  <= 1'b0;
			n_unm_ack <= 1'b0;
			unm_ack   <= 1'b0;
		end else begin
			if (mapped_req)
				bank_q <= req_bank;
			if (unm_req)
				unm_pend <= 1'b1;
			else if (mapped_req)
				unm_pend <= 1'b0;
			// Same strobe timing as a bank.
			if (unm_req)
				n_unm_ack <= 1'b1;
			else if (clk_div)
				n_unm_ack <= 1'b0;
			if (clk_div)
				unm_ack <= n_unm_ack;
		end
	end

	// Unmapped reads return zero.
	assign mem_ack   = unm_pend ? unm_ack : bank_ack[bank_q];
	assign mem_rdata = unm_pend ? '0 : bank_rdata[bank_q];

endmodule

`default_nettype wire

// File: hdl/ram_1r1w.sv
//**************************************************************************
// Single read, single write table RAM.
// Synchronous write, registered read data, no reset on contents.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module ram_1r1w (
	input  wire logic              clk,
	input  wire logic              wr,
	input  wire tbl_pkg::tbl_addr_t raddr,
	input  wire tbl_pkg::tbl_addr_t waddr,
	input  wire tbl_pkg::tbl_data_t din,
	output      tbl_pkg::tbl_data_t dout
);

	import tbl_pkg::*;

	localparam int depth = 1 << tbl_depth_nbits;  // Entries in the array.

	tbl_data_t mem [depth];                       // Undefined until written.

	// Write port.
	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
	end

	// Read port, one cycle from address to data.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];                       // Old data on a same-address write.
	end

endmodule

`default_nettype wire

// File: hdl/tbl_pkg.sv
//**************************************************************************
// Lookup table geometry.
// Entry width, depth per bank, bank count and matching types.
//**************************************************************************

`default_nettype none

package tbl_pkg;

	localparam int tbl_width       = 20;        // Bits per table entry.
	localparam int tbl_depth_nbits = 10;        // 1024 entries per bank.

	// Bank count follows the bank index field of the bus address.
	localparam int num_banks = 1 << pio_pkg::bank_sel_nbits;

	typedef logic [tbl_width-1:0]       tbl_data_t;   // One table entry.
	typedef logic [tbl_depth_nbits-1:0] tbl_addr_t;   // Entry index in a bank.

	// Bank number as carried on the bus.
	typedef logic [pio_pkg::bank_sel_nbits-1:0] bank_idx_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the lookup table testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_lookup_tables -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_lookup_tables)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1

// File: tb.f
hdl/pio_pkg.sv
hdl/tbl_pkg.sv
hdl/ram_1r1w.sv
hdl/pio_decode.sv
hdl/pio_mem.sv
hdl/pio_resp_merge.sv
hdl/lookup_tables.sv
tb/lookup_tables_properties.sv
tb/tb_lookup_tables.sv

// File: tb/lookup_tables_properties.sv
//**************************************************************************
// Bound checks for the lookup table banks and top level.
// Application ack delay, ack strobe timing and one-hot bank select.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module lookup_tables_properties (
	input wire logic                          clk,
	input wire logic                          arst_n,
	input wire logic                          clk_div,
	input wire logic [tbl_pkg::num_banks-1:0] mem_ack,
	input wire logic [tbl_pkg::num_banks-1:0] app_mem_rd,
	input wire logic [tbl_pkg::num_banks-1:0] app_mem_ack,
	input wire logic [tbl_pkg::num_banks-1:0] sel
);

	// Ack trails each read by exactly three cycles.
	app_ack_delay: assert property (@(posedge clk) disable iff (!arst_n)
		app_mem_ack == $past(app_mem_rd, 3))
		else $error("app_mem_ack does not trail app_mem_rd by three cycles");

	// PIO ack moves only on the divider strobe.
	ack_on_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_ack != $past(mem_ack)) |-> $past(clk_div))
		else $error("mem_ack changed without clk_div");

	bank_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(sel))
		else $error("bank select is not one-hot");

endmodule

// Single-bit bank signals are copied across the vector ports.
// In a bank, a RAM write never meets an issued PIO read.
bind pio_mem lookup_tables_properties u_bank_props (
	.clk         (clk),
	.arst_n      (arst_n),
	.clk_div     (clk_div),
	.mem_ack     ({tbl_pkg::num_banks{mem_ack}}),
	.app_mem_rd  ({tbl_pkg::num_banks{app_mem_rd}}),
	.app_mem_ack ({tbl_pkg::num_banks{app_mem_ack}}),
	.sel         ({{(tbl_pkg::num_banks-2){1'b0}}, ram_wr, rd_issue})
);

bind lookup_tables lookup_tables_properties u_top_props (
	.clk         (clk),
	.arst_n      (arst_n),
	.clk_div     (clk_div),
	.mem_ack     (bank_ack),
	.app_mem_rd  (app_mem_rd),
	.app_mem_ack (app_mem_ack),
	.sel         (bank_ms)
);

`default_nettype wire

// File: tb/tb_lookup_tables.sv
//**************************************************************************
// Testbench for the lookup table subsystem.
// PIO and application traffic checked against a shadow copy of the tables.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_lookup_tables;

	import pio_pkg::*;
	import tbl_pkg::*;

	localparam int n_idx      = 8;                // Written entries per bank.
	localparam int max_cycles = 20000;            // About 2000 cycles of traffic, wide margin.

	logic                      clk;
	logic                      arst_n;
	logic                      clk_div;
	pio_word_t                 reg_addr;
	pio_word_t                 reg_din;
	logic                      reg_rd;
	logic                      reg_wr;
	logic [num_banks-1:0]      app_mem_rd;
	tbl_addr_t [num_banks-1:0] app_mem_raddr;
	logic                      mem_ack;
	pio_word_t                 mem_rdata;
	logic [num_banks-1:0]      app_mem_ack;
	tbl_data_t [num_banks-1:0] app_mem_rdata;

	tbl_data_t shadow [num_banks][1 << tbl_depth_nbits];  // Reference copy of the tables.
	tbl_addr_t used_idx [num_banks][n_idx];     // Entries known to be written.
	int        div_cnt;
	int        cycles;
	int        checks;
	int        errors;
	logic      pio_is_rd;                       // Current PIO access is a read.
	pio_word_t pio_exp;                         // Its expected read data.
	logic      mem_ack_q;
	bit        app_vld [num_banks][3];          // App reads in flight.
	tbl_data_t app_exp [num_banks][3];

	lookup_tables DUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.clk_div       (clk_div),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.app_mem_rd    (app_mem_rd),
		.app_mem_raddr (app_mem_raddr),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.app_mem_ack   (app_mem_ack),
		.app_mem_rdata (app_mem_rdata)
	);

	always #50 clk = ~clk;

	// Divider strobe, one cycle in four.
	always @(posedge clk) begin
		#10;
		div_cnt = (div_cnt + 1) % 4;
		clk_div = (div_cnt == 3);
	end

	function automatic logic is_mapped(pio_word_t addr);
		return ~|addr[pio_nbits-1:pio_map_msb+1];  // Nothing set above bit 13.
	endfunction

	function automatic pio_word_t bus_addr(int b, tbl_addr_t i);
		return (pio_word_t'(b) << bank_lsb) | (pio_word_t'(i) << 2);  // Byte address.
	endfunction

	// Expected PIO word for a bus address.
	function automatic pio_word_t ref_word(pio_word_t addr);
		bank_idx_t b;
		tbl_addr_t i;
		b = addr[bank_lsb +: bank_sel_nbits];
		i = addr[2 +: tbl_depth_nbits];
		if (!is_mapped(addr))
			return '0;
		return {{(pio_nbits-tbl_width){1'b0}}, shadow[b][i]};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	// One PIO access, done at the rising edge of mem_ack.
	task automatic pio_access(pio_word_t addr, pio_word_t data, logic rd);
		while (mem_ack)
			next_cycle();                          // Last ack must drop first.
		pio_is_rd = rd;
		pio_exp   = ref_word(addr);
		reg_addr  = addr;
		reg_din   = data;
		reg_rd    = rd;
		reg_wr    = ~rd;
		next_cycle();
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		while (!mem_ack)
			next_cycle();
	endtask

	task automatic pio_write(pio_word_t addr, pio_word_t data);
		pio_access(addr, data, 1'b0);
		if (is_mapped(addr))
			shadow[addr[bank_lsb +: bank_sel_nbits]][addr[2 +: tbl_depth_nbits]] =
				data[tbl_width-1:0];
	endtask

	task automatic read_back();
		for (int bk = 0; bk < num_banks; bk++)
			for (int k = 0; k < n_idx; k++)
				pio_access(bus_addr(bk, used_idx[bk][k]), '0, 1'b1);
	endtask

	// Application reads on one bank with random gaps.
	task automatic app_gapped(int bk, int n);
		for (int k = 0; k < n; k++) begin
			app_mem_rd[bk]    = 1'($urandom_range(1, 0));
			app_mem_raddr[bk] = used_idx[bk][$urandom_range(n_idx-1, 0)];
			next_cycle();
		end
		app_mem_rd[bk] = 1'b0;
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// Compare process, samples between the edge and the next drive.
	always @(posedge clk) begin
		pio_word_t w;
		#5;
		for (int b = 0; b < num_banks; b++) begin
			app_vld[b][2] = app_vld[b][1];
			app_exp[b][2] = app_exp[b][1];
			app_vld[b][1] = app_vld[b][0];
			app_exp[b][1] = app_exp[b][0];
			w = ref_word(bus_addr(b, app_mem_raddr[b]));
			app_vld[b][0] = app_mem_rd[b];          // Taken at this edge.
			app_exp[b][0] = w[tbl_width-1:0];
			checks++;
			assert (app_mem_ack[b] == app_vld[b][2]) else begin
				errors++;
				$display("mismatch at %0t: app_mem_ack[%0d] expected %b actual %b",
					$time, b, app_vld[b][2], app_mem_ack[b]);
			end
			if (app_vld[b][2]) begin
				checks++;
				assert (app_mem_rdata[b] === app_exp[b][2]) else begin
					errors++;
					$display("mismatch at %0t: app_mem_rdata[%0d] expected %h actual %h",
						$time, b, app_exp[b][2], app_mem_rdata[b]);
				end
			end
		end
		if (mem_ack && !mem_ack_q && pio_is_rd) begin
			checks++;
			assert (mem_rdata === pio_exp) else begin
				errors++;
				$display("mismatch at %0t: mem_rdata expected %h actual %h",
					$time, pio_exp, mem_rdata);
			end
		end
		mem_ack_q = mem_ack;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == max_cycles) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			errors++;
			finish_run();
		end
	end

	initial begin
		pio_word_t addr;
		void'($urandom(32'h5a01));
		clk           = 1'b0;
		arst_n        = 1'b0;
		clk_div       = 1'b0;
		reg_addr      = '0;
		reg_din       = '0;
		reg_rd        = 1'b0;
		reg_wr        = 1'b0;
		app_mem_rd    = '0;
		app_mem_raddr = '0;
		div_cnt       = 0;
		cycles        = 0;
		checks        = 0;
		errors        = 0;
		pio_is_rd     = 1'b0;
		pio_exp       = '0;
		mem_ack_q     = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		arst_n = 1'b1;
		repeat (3) next_cycle();
		// Quiet outputs before any request.
		checks++;
		assert (mem_ack == 1'b0 && app_mem_ack == '0) else begin
			errors++;
			$display("mismatch at %0t: mem_ack/app_mem_ack expected 0/0 actual %b/%b",
				$time, mem_ack, app_mem_ack);
		end
		// PIO writes to all banks, then read back.
		for (int bk = 0; bk < num_banks; bk++)
			for (int k = 0; k < n_idx; k++) begin
				used_idx[bk][k] = tbl_addr_t'($urandom);
				pio_write(bus_addr(bk, used_idx[bk][k]), $urandom);
			end
		read_back();
		// Back-to-back application reads on every bank.
		for (int k = 0; k < 16; k++) begin
			for (int bk = 0; bk < num_banks; bk++) begin
				app_mem_rd[bk]    = 1'b1;
				app_mem_raddr[bk] = used_idx[bk][$urandom_range(n_idx-1, 0)];
			end
			next_cycle();
		end
		app_mem_rd = '0;
		repeat (4) next_cycle();
		// PIO reads against gapped application reads on the same bank.
		for (int bk = 0; bk < num_banks; bk++) begin
			fork
				app_gapped(bk, 40);
				for (int k = 0; k < 4; k++)
					pio_access(bus_addr(bk, used_idx[bk][$urandom_range(n_idx-1, 0)]),
						'0, 1'b1);
			join
			repeat (4) next_cycle();
		end
		// Unmapped writes and reads, then confirm the tables.
		for (int bk = 0; bk < num_banks; bk++) begin
			addr = bus_addr(bk, used_idx[bk][0]) |
				(pio_word_t'(1) << $urandom_range(pio_nbits-1, pio_map_msb+1));
			pio_write(addr, $urandom);
			pio_access(addr, '0, 1'b1);              // Zero data expected.
		end
		read_back();
		repeat (4) next_cycle();
		finish_run();
	end

endmodule

`default_nettype wire
